// File: logic/jtframe_inputs.sv
/* Joystick input mapping
   Two-stage synchroniser, polarity and button masking,
   coin, start and service fields, pause toggle */

`default_nettype none

module jtframe_inputs(
    input  wire        clk_sys,
    input  wire        arst_n,
    input  wire        game_rst,
    input  wire  [9:0] board_joystick1,  // Active high from the board
    input  wire  [9:0] board_joystick2,
    output logic [9:0] game_joystick1,
    output logic [9:0] game_joystick2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       game_pause,       // Active high toggle
    output logic       game_service
);

logic [9:0] joy1_s1;
logic [9:0] joy1_s2;
logic [9:0] joy2_s1;
logic [9:0] joy2_s2;
logic [9:0] joy1_map;
logic [9:0] joy2_map;
logic       pause_last;

// Board to game polarity, button 3 dropped on two-button games
function automatic logic [9:0] map_joy(input logic [9:0] raw);
    logic [9:0] act;
    act = raw;
    if (!jtframe_pkg::THREE_BUTTONS) begin
        act[6] = 1'b0;
    end
    return jtframe_pkg::GAME_INPUTS_ACTIVE_HIGH ? act : ~act;
endfunction

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        joy1_s1 <= '0;
        joy1_s2 <= '0;
        joy2_s1 <= '0;
        joy2_s2 <= '0;
    end else begin
        joy1_s1 <= board_joystick1;
        joy1_s2 <= joy1_s1;
        joy2_s1 <= board_joystick2;
        joy2_s2 <= joy2_s1;
    end
end

assign joy1_map = map_joy(joy1_s2);
assign joy2_map = map_joy(joy2_s2);

assign game_joystick1 = joy1_map;
assign game_joystick2 = joy2_map;
assign game_coin      = { joy2_map[8], joy1_map[8] };  // Player 1 in bit 0
assign game_start     = { joy2_map[7], joy1_map[7] };
assign game_service   = joy2_map[9];

// Pause button is stick 1 bit 9, toggled on each press
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        pause_last <= 1'b0;
        game_pause <= 1'b0;
    end else begin
        pause_last <= joy1_s2[9];
        if (game_rst) begin
            game_pause <= 1'b0;
        end else if (joy1_s2[9] && !pause_last) begin
            game_pause <= ~game_pause;
        end
    end
end

endmodule

`default_nettype wire

// File: logic/jtframe_mist.sv
/* Board framework top level
   Connects reset generation, joystick mapping and the
   ROM memory controller */

`default_nettype none

module jtframe_mist(
    input  wire                            clk_sys,
    input  wire                            arst_n,
    input  wire                            pll_locked,
    // Reset forcing
    input  wire                            dip_flip,
    input  wire                            rst_req,
    input  wire                            downloading,
    output wire                            rst,
    output wire                            rst_n,
    output wire                            game_rst,
    output wire                            game_rst_n,
    output wire                            led,
    // ROM access from game
    input  wire                            refresh_en,
    input  wire                            sdram_req,
    input  wire  [jtframe_pkg::ROM_AW-1:0] sdram_addr,
    output wire                            sdram_ack,
    output wire  [31:0]                    data_read,
    output wire                            data_rdy,
    output wire                            loop_rst,
    // ROM load
    input  wire  [jtframe_pkg::ROM_AW-1:0] prog_addr,
    input  wire  [7:0]                     prog_data,
    input  wire  [1:0]                     prog_mask,
    input  wire                            prog_we,
    // Memory request port
    output wire  [jtframe_pkg::MEM_AW-1:0] mem_addr,
    output wire  [15:0]                    mem_din,
    output wire  [1:0]                     mem_be,
    output wire                            mem_rd,
    output wire                            mem_we,
    output wire                            mem_refresh,
    input  wire  [15:0]                    mem_dout,
    input  wire                            mem_rdy,
    // Joysticks
    input  wire  [9:0]                     board_joystick1,
    input  wire  [9:0]                     board_joystick2,
    output wire  [9:0]                     game_joystick1,
    output wire  [9:0]                     game_joystick2,
    output wire  [1:0]                     game_coin,
    output wire  [1:0]                     game_start,
    output wire                            game_pause,
    output wire                            game_service
);

jtframe_reset u_reset(
    .clk_sys        ( clk_sys         ),
    .arst_n         ( arst_n          ),
    .pll_locked     ( pll_locked      ),
    .dip_flip       ( dip_flip        ),
    .rst_req        ( rst_req         ),
    .downloading    ( downloading     ),
    .rst            ( rst             ),
    .rst_n          ( rst_n           ),
    .game_rst       ( game_rst        ),
    .game_rst_n     ( game_rst_n      ),
    .led            ( led             )
);

jtframe_inputs u_inputs(
    .clk_sys        ( clk_sys         ),
    .arst_n         ( arst_n          ),
    .game_rst       ( game_rst        ),
    .board_joystick1( board_joystick1 ),
    .board_joystick2( board_joystick2 ),
    .game_joystick1 ( game_joystick1  ),
    .game_joystick2 ( game_joystick2  ),
    .game_coin      ( game_coin       ),
    .game_start     ( game_start      ),
    .game_pause     ( game_pause      ),
    .game_service   ( game_service    )
);

jtframe_rom_mux u_rom_mux(
    .clk_sys        ( clk_sys         ),
    .arst_n         ( arst_n          ),
    .rst            ( rst             ),
    .downloading    ( downloading     ),
    .refresh_en     ( refresh_en      ),
    // Game side
    .sdram_req      ( sdram_req       ),
    .sdram_addr     ( sdram_addr      ),
    .sdram_ack      ( sdram_ack       ),
    .data_read      ( data_read       ),
    .data_rdy       ( data_rdy        ),
    .loop_rst       ( loop_rst        ),
    // Loader side
    .prog_addr      ( prog_addr       ),
    .prog_data      ( prog_data       ),
    .prog_mask      ( prog_mask       ),
    .prog_we        ( prog_we         ),
    // Memory side
    .mem_addr       ( mem_addr        ),
    .mem_din        ( mem_din         ),
    .mem_be         ( mem_be          ),
    .mem_rd         ( mem_rd          ),
    .mem_we         ( mem_we          ),
    .mem_refresh    ( mem_refresh     ),
    .mem_dout       ( mem_dout        ),
    .mem_rdy        ( mem_rdy         )
);

endmodule

`default_nettype wire

// File: logic/jtframe_pkg.sv
/* Shared constants for the board framework
   Reset stretch lengths, input polarity options, memory widths
   and the memory controller state encoding */

`default_nettype none

package jtframe_pkg;

    // Reset generation
    localparam int RST_CYCLES = 16;
    localparam int RST_CW     = $clog2(RST_CYCLES + 1);
    localparam logic [RST_CW-1:0] RST_LOAD = RST_CW'(RST_CYCLES);

    // Game input options
    localparam bit GAME_INPUTS_ACTIVE_HIGH = 1'b0;  // 0 gives active low buses
    localparam bit THREE_BUTTONS           = 1'b0;  // 0 forces button 3 off

    // Address widths
    localparam int ROM_AW = 22;     // Loader byte address
    localparam int MEM_AW = 21;     // 16-bit word address

    // Memory refresh timer
    localparam int REFRESH_PERIOD = 64;
    localparam int REF_CW         = $clog2(REFRESH_PERIOD);
    localparam logic [REF_CW-1:0] REF_LAST = REF_CW'(REFRESH_PERIOD - 1);

    // Controller start-up delay after rst
    localparam int INIT_CYCLES = 8;
    localparam int INIT_CW     = $clog2(INIT_CYCLES + 1);
    localparam logic [INIT_CW-1:0] INIT_LOAD = INIT_CW'(INIT_CYCLES);

    // Memory controller states
    typedef enum logic [2:0] {
        ST_INIT,        // Waiting out loop_rst
        ST_IDLE,
        ST_WRITE,       // Download byte in flight
        ST_READ_LO,
        ST_READ_HI,
        ST_REFRESH
    } mem_state_e;

endpackage

`default_nettype wire

// File: logic/jtframe_reset.sv
/* System and game reset generation
   Stretches rst after PLL lock, restarts game_rst on requests
   and on DIP flip changes, drives the status LED */

`default_nettype none

module jtframe_reset(
    input  wire  clk_sys,
    input  wire  arst_n,
    input  wire  pll_locked,
    input  wire  dip_flip,      // Any change resets the game
    input  wire  rst_req,
    input  wire  downloading,
    output logic rst,
    output logic rst_n,
    output logic game_rst,
    output logic game_rst_n,
    output logic led
);

logic [jtframe_pkg::RST_CW-1:0] rst_cnt;
logic [jtframe_pkg::RST_CW-1:0] game_cnt;
logic                           last_flip;
logic                           game_trig;

// Triggers are ignored while the whole board is in reset
assign game_trig = ~rst & (rst_req | (dip_flip != last_flip));

// System reset, released synchronously once the PLL is stable
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        rst_cnt <= jtframe_pkg::RST_LOAD;
        rst     <= 1'b1;
    end else if (!pll_locked) begin
        rst_cnt <= jtframe_pkg::RST_LOAD;  // Restart on lock loss
        rst     <= 1'b1;
    end else begin
        if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
        rst <= |rst_cnt[jtframe_pkg::RST_CW-1:1];   // Count above 1
    end
end

// Game reset stretch
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        game_cnt  <= '0;
        last_flip <= 1'b0;
        game_rst  <= 1'b1;
    end else begin
        last_flip <= dip_flip;
        if (game_trig) begin
            game_cnt <= jtframe_pkg::RST_LOAD;
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end
        game_rst <= rst | downloading | game_trig |
                    (|game_cnt[jtframe_pkg::RST_CW-1:1]);
    end
end

assign rst_n      = ~rst;
assign game_rst_n = ~game_rst;

// Dark while loading, without PLL lock or in reset
assign led = ~(downloading | ~pll_locked | rst);

endmodule

`default_nettype wire

// File: logic/jtframe_rom_mux.sv
/* ROM memory controller
   Loader byte writes through a one-entry buffer, refresh timer
   and 32-bit game reads built from two 16-bit accesses */

`default_nettype none

module jtframe_rom_mux(
    input  wire                            clk_sys,
    input  wire                            arst_n,
    input  wire                            rst,
    input  wire                            downloading,
    input  wire                            refresh_en,
    // Game side
    input  wire                            sdram_req,
    input  wire  [jtframe_pkg::ROM_AW-1:0] sdram_addr,  // Byte address
    output logic                           sdram_ack,
    output logic [31:0]                    data_read,
    output logic                           data_rdy,
    output logic                           loop_rst,
    // Loader side
    input  wire  [jtframe_pkg::ROM_AW-1:0] prog_addr,
    input  wire  [7:0]                     prog_data,
    input  wire  [1:0]                     prog_mask,   // Active low lanes
    input  wire                            prog_we,
    // Memory side
    output logic [jtframe_pkg::MEM_AW-1:0] mem_addr,
    output logic [15:0]                    mem_din,
    output logic [1:0]                     mem_be,
    output logic                           mem_rd,
    output logic                           mem_we,
    output logic                           mem_refresh,
    input  wire  [15:0]                    mem_dout,
    input  wire                            mem_rdy
);

jtframe_pkg::mem_state_e         state;
logic [jtframe_pkg::INIT_CW-1:0] init_cnt;
logic [jtframe_pkg::REF_CW-1:0]  ref_cnt;
logic                            ref_due;
logic                            wr_pend;
logic [jtframe_pkg::ROM_AW-1:0]  wr_addr;
logic [7:0]                      wr_data;
logic [1:0]                      wr_mask;
logic [jtframe_pkg::MEM_AW-1:0]  rd_next;   // Word holding the upper half
logic                            idle;
logic                            issue_wr;
logic                            issue_ref;
logic                            issue_rd;
logic                            rd_lo_done;
logic                            rd_hi_done;

// Priority in idle: buffered write, due refresh, game read
assign idle       = state == jtframe_pkg::ST_IDLE;
assign issue_wr   = idle & wr_pend;
assign issue_ref  = idle & ~wr_pend & ref_due;
assign issue_rd   = idle & ~wr_pend & ~ref_due & sdram_req & ~downloading;
assign rd_lo_done = (state == jtframe_pkg::ST_READ_LO) & mem_rdy;
assign rd_hi_done = (state == jtframe_pkg::ST_READ_HI) & mem_rdy;

always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        state       <= jtframe_pkg::ST_INIT;
        init_cnt    <= jtframe_pkg::INIT_LOAD;
        loop_rst    <= 1'b1;
        wr_pend     <= 1'b0;
        sdram_ack   <= 1'b0;
        data_rdy    <= 1'b0;
        mem_rd      <= 1'b0;
        mem_we      <= 1'b0;
        mem_refresh <= 1'b0;
    end else if (rst) begin
        state       <= jtframe_pkg::ST_INIT;
        init_cnt    <= jtframe_pkg::INIT_LOAD;
        loop_rst    <= 1'b1;
        wr_pend     <= 1'b0;
        sdram_ack   <= 1'b0;
        data_rdy    <= 1'b0;
        mem_rd      <= 1'b0;
        mem_we      <= 1'b0;
        mem_refresh <= 1'b0;
    end else begin
        // One-cycle strobes
        sdram_ack   <= issue_rd;
        data_rdy    <= rd_hi_done;
        mem_we      <= issue_wr;
        mem_refresh <= issue_ref;
        mem_rd      <= issue_rd | rd_lo_done;     // Second read follows the first
        if (issue_wr) begin
            wr_pend <= 1'b0;
        end
        if (prog_we) begin
            wr_pend <= 1'b1;                      // New byte wins over the drain
        end
        case (state)
            jtframe_pkg::ST_INIT: begin
                if (|init_cnt[jtframe_pkg::INIT_CW-1:1]) begin
                    init_cnt <= init_cnt - 1'b1;
                end else begin
                    loop_rst <= 1'b0;
                    state    <= jtframe_pkg::ST_IDLE;
                end
            end
            jtframe_pkg::ST_IDLE: begin
                if (issue_wr) begin
                    state <= jtframe_pkg::ST_WRITE;
                end else if (issue_ref) begin
                    state <= jtframe_pkg::ST_REFRESH;
                end else if (issue_rd) begin
                    state <= jtframe_pkg::ST_READ_LO;
                end
            end
            jtframe_pkg::ST_READ_LO: begin
                if (mem_rdy) begin
                    state <= jtframe_pkg::ST_READ_HI;
                end
            end
            jtframe_pkg::ST_WRITE, jtframe_pkg::ST_READ_HI,
            jtframe_pkg::ST_REFRESH: begin
                if (mem_rdy) begin
                    state <= jtframe_pkg::ST_IDLE;
                end
            end
            default: state <= jtframe_pkg::ST_IDLE;
        endcase
    end
end

// Refresh timer, runs only while the game allows it
always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        ref_cnt <= '0;
        ref_due <= 1'b0;
    end else if (rst || !refresh_en) begin
        ref_cnt <= '0;
        ref_due <= 1'b0;
    end else begin
        if (issue_ref) begin
            ref_due <= 1'b0;
        end
        if (ref_cnt == jtframe_pkg::REF_LAST) begin
            ref_cnt <= '0;
            ref_due <= 1'b1;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end
end

// Write buffer, command payload and read assembly
always_ff @(posedge clk_sys) begin
    if (prog_we) begin
        wr_addr <= prog_addr;
        wr_data <= prog_data;
        wr_mask <= prog_mask;
    end
    if (issue_wr) begin
        mem_addr <= wr_addr[jtframe_pkg::ROM_AW-1:1];
        mem_din  <= {2{wr_data}};                        // Byte on both lanes
        mem_be   <= ~wr_mask & (wr_addr[0] ? 2'b10 : 2'b01);
    end else if (issue_rd) begin
        mem_addr <= sdram_addr[jtframe_pkg::ROM_AW-1:1];
        rd_next  <= sdram_addr[jtframe_pkg::ROM_AW-1:1] + 1'b1;
        mem_be   <= 2'b11;
    end else if (rd_lo_done) begin
        mem_addr <= rd_next;
    end
    if (rd_lo_done) begin
        data_read[15:0] <= mem_dout;
    end
    if (rd_hi_done) begin
        data_read[31:16] <= mem_dout;
    end
end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the board framework testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f sources.f --top-module tb_jtframe_mist \
        -Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb; then
    echo "Simulation returned a failing status"
    exit 1
fi

exit 0

// File: sources.f
logic/jtframe_pkg.sv
logic/jtframe_reset.sv
logic/jtframe_inputs.sv
logic/jtframe_rom_mux.sv
logic/jtframe_mist.sv
testbench/tb_mem_model.sv
testbench/tb_jtframe_mist.sv

// File: testbench/tb_jtframe_mist.sv
/* Testbench for the board framework top level
   Directed tests for resets, joystick mapping, ROM download,
   game reads and refresh arbitration, with a watchdog */

`default_nettype none

module tb_jtframe_mist;

timeunit 1ns;
timeprecision 1ps;

localparam int          CLK_PERIOD  = 4;
localparam logic [15:0] LFSR_SEED   = 16'd32541;
localparam logic [21:0] WIN_BASE    = 22'h15A3C0;    // Download window
localparam int          N_JOY       = 16;
localparam int          N_WR        = 48;
localparam int          N_RD        = 24;
localparam int          N_REF_RD    = 12;
localparam int          WR_GAP      = 12;
localparam int          HOLD_CYCLES = 30;
localparam int          IDLE_TAIL   = 200;
localparam int          WAIT_LIMIT  = 40;            // Per handshake
localparam int          READ_MAX    = 2 * WAIT_LIMIT + 2;
localparam int          TEST_CYCLES = 250 + 2 * N_JOY + N_WR * (WR_GAP + 4) +
                                      (N_RD + 1) * READ_MAX + HOLD_CYCLES +
                                      N_REF_RD * (32 + READ_MAX) + IDLE_TAIL;
localparam int          WATCHDOG    = TEST_CYCLES + 500;

logic        clk_sys = 1'b0;
logic        arst_n;
logic        pll_locked;
logic        dip_flip;
logic        rst_req;
logic        downloading;
logic        refresh_en;
logic        sdram_req;
logic [21:0] sdram_addr;
logic [21:0] prog_addr;
logic [7:0]  prog_data;
logic [1:0]  prog_mask;
logic        prog_we;
logic [9:0]  board_joystick1;
logic [9:0]  board_joystick2;
wire         rst;
wire         rst_n;
wire         game_rst;
wire         game_rst_n;
wire         led;
wire         sdram_ack;
wire  [31:0] data_read;
wire         data_rdy;
wire         loop_rst;
wire  [20:0] mem_addr;
wire  [15:0] mem_din;
wire  [1:0]  mem_be;
wire         mem_rd;
wire         mem_we;
wire         mem_refresh;
wire  [15:0] mem_dout;
wire         mem_rdy;
wire  [9:0]  game_joystick1;
wire  [9:0]  game_joystick2;
wire  [1:0]  game_coin;
wire  [1:0]  game_start;
wire         game_pause;
wire         game_service;

logic [15:0] lfsr_state;
logic [7:0]  shadow [int];   // Bytes written by the loader
int          refresh_seen = 0;

always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

always @(negedge clk_sys) begin
    if (mem_refresh === 1'b1) begin
        refresh_seen <= refresh_seen + 1;
    end
end

jtframe_mist u_dut(
    .clk_sys(clk_sys), .arst_n(arst_n), .pll_locked(pll_locked),
    .dip_flip(dip_flip), .rst_req(rst_req), .downloading(downloading),
    .rst(rst), .rst_n(rst_n), .game_rst(game_rst), .game_rst_n(game_rst_n),
    .led(led), .refresh_en(refresh_en), .sdram_req(sdram_req),
    .sdram_addr(sdram_addr), .sdram_ack(sdram_ack), .data_read(data_read),
    .data_rdy(data_rdy), .loop_rst(loop_rst), .prog_addr(prog_addr),
    .prog_data(prog_data), .prog_mask(prog_mask), .prog_we(prog_we),
    .mem_addr(mem_addr), .mem_din(mem_din), .mem_be(mem_be), .mem_rd(mem_rd),
    .mem_we(mem_we), .mem_refresh(mem_refresh), .mem_dout(mem_dout),
    .mem_rdy(mem_rdy), .board_joystick1(board_joystick1),
    .board_joystick2(board_joystick2), .game_joystick1(game_joystick1),
    .game_joystick2(game_joystick2), .game_coin(game_coin),
    .game_start(game_start), .game_pause(game_pause), .game_service(game_service)
);

tb_mem_model u_mem(
    .clk_sys(clk_sys), .arst_n(arst_n), .mem_addr(mem_addr), .mem_din(mem_din),
    .mem_be(mem_be), .mem_rd(mem_rd), .mem_we(mem_we), .mem_refresh(mem_refresh),
    .mem_dout(mem_dout), .mem_rdy(mem_rdy)
);

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

// Same fill rule as the memory model
function automatic logic [15:0] fill_word(input logic [20:0] a);
    return {a[7:0], a[15:8]} ^ {11'h000, a[20:16]} ^ 16'h5A3C;
endfunction

function automatic logic [7:0] expect_byte(input logic [21:0] b);
    logic [15:0] w;
    w = fill_word(b[21:1]);
    if (shadow.exists(int'(b))) begin
        return shadow[int'(b)];
    end
    return b[0] ? w[15:8] : w[7:0];
endfunction

function automatic logic [31:0] expect_read(input logic [21:0] a);
    logic [21:0] b;
    b = {a[21:1], 1'b0};
    return {expect_byte(b + 22'd3), expect_byte(b + 22'd2),
            expect_byte(b + 22'd1), expect_byte(b)};
endfunction

// Active low, button 3 held released
function automatic logic [9:0] expect_joy(input logic [9:0] raw);
    return ~raw | 10'h040;
endfunction

task automatic stop_run(input string reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", reason);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_run("Single-bit output mismatch");
    end
endtask

task automatic check_pair(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_run("Two-bit field mismatch");
    end
endtask

task automatic check_joy(input string name, input logic [9:0] got, input logic [9:0] exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_run("Joystick bus mismatch");
    end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_run("Read data mismatch");
    end
endtask

// From the first edge with arst_n and pll_locked both good
task automatic check_release();
    for (int i = 1; i < jtframe_pkg::RST_CYCLES; i++) begin
        @(negedge clk_sys);
        check_bit("rst", rst, 1'b1);
        check_bit("led", led, 1'b0);
    end
    @(negedge clk_sys);
    check_bit("rst", rst, 1'b0);
    check_bit("rst_n", rst_n, 1'b1);
    check_bit("led", led, 1'b1);
    check_bit("game_rst", game_rst, 1'b1);   // Follows rst a cycle late
    for (int i = 1; i < jtframe_pkg::INIT_CYCLES; i++) begin
        @(negedge clk_sys);
        check_bit("loop_rst", loop_rst, 1'b1);
    end
    @(negedge clk_sys);
    check_bit("loop_rst", loop_rst, 1'b0);
    check_bit("game_rst_n", game_rst_n, 1'b1);
endtask

task automatic check_game_stretch();
    for (int i = 0; i < jtframe_pkg::RST_CYCLES; i++) begin
        @(negedge clk_sys);
        rst_req = 1'b0;
        check_bit("game_rst", game_rst, 1'b1);
        check_bit("rst", rst, 1'b0);
    end
    @(negedge clk_sys);
    check_bit("game_rst", game_rst, 1'b0);
endtask

task automatic check_sticks(input logic [9:0] raw1, input logic [9:0] raw2);
    logic [9:0] exp1;
    logic [9:0] exp2;
    exp1 = expect_joy(raw1);
    exp2 = expect_joy(raw2);
    check_joy("game_joystick1", game_joystick1, exp1);
    check_joy("game_joystick2", game_joystick2, exp2);
    check_pair("game_coin", game_coin, {exp2[8], exp1[8]});
    check_pair("game_start", game_start, {exp2[7], exp1[7]});
    check_bit("game_service", game_service, exp2[9]);
endtask

task automatic press_pause();
    board_joystick1 = 10'h200;
    repeat (4) @(negedge clk_sys);
    board_joystick1 = '0;
    repeat (4) @(negedge clk_sys);
endtask

// One request, one ack, one data_rdy with the predicted word
task automatic read_and_check(input logic [21:0] addr);
    int waited;
    logic [31:0] exp;
    exp = expect_read(addr);
    sdram_req = 1'b1;
    sdram_addr = addr;
    waited = 0;
    do begin
        @(negedge clk_sys);
        waited++;
        if (waited > WAIT_LIMIT) stop_run("Game read was never acknowledged");
    end while (sdram_ack !== 1'b1);
    sdram_req = 1'b0;
    waited = 0;
    do begin
        @(negedge clk_sys);
        waited++;
        check_bit("sdram_ack", sdram_ack, 1'b0);
        if (waited > WAIT_LIMIT) stop_run("No data_rdy after the read was acknowledged");
    end while (data_rdy !== 1'b1);
    check_word("data_read", data_read, exp);
    @(negedge clk_sys);
    check_bit("data_rdy", data_rdy, 1'b0);
endtask

task automatic test_reset();
    repeat (4) @(negedge clk_sys);
    arst_n = 1'b1;
    check_release();
    pll_locked = 1'b0;                        // Lock loss
    @(negedge clk_sys);
    check_bit("rst", rst, 1'b1);
    check_bit("led", led, 1'b0);
    repeat (2) @(negedge clk_sys);
    pll_locked = 1'b1;
    check_release();
endtask

task automatic test_game_reset();
    rst_req = 1'b1;
    check_game_stretch();
    dip_flip = ~dip_flip;
    check_game_stretch();
    downloading = 1'b1;
    for (int i = 0; i < 20; i++) begin
        @(negedge clk_sys);
        check_bit("game_rst", game_rst, 1'b1);
        check_bit("led", led, 1'b0);
    end
    downloading = 1'b0;
    @(negedge clk_sys);
    check_bit("game_rst", game_rst, 1'b0);
    check_bit("led", led, 1'b1);
endtask

task automatic test_inputs();
    logic [9:0] raw1;
    logic [9:0] raw2;
    logic [9:0] old1;
    logic [9:0] old2;
    old1 = board_joystick1;
    old2 = board_joystick2;
    for (int i = 0; i < N_JOY; i++) begin
        raw1 = 10'(take_bits(10)) & 10'h1FF;  // Pause kept up
        raw2 = 10'(take_bits(10));
        board_joystick1 = raw1;
        board_joystick2 = raw2;
        @(negedge clk_sys);
        check_sticks(old1, old2);             // Still in the synchroniser
        @(negedge clk_sys);
        check_sticks(raw1, raw2);
        old1 = raw1;
        old2 = raw2;
    end
    board_joystick1 = '0;
    board_joystick2 = '0;
    repeat (4) @(negedge clk_sys);
    check_bit("game_pause", game_pause, 1'b0);
    press_pause();
    check_bit("game_pause", game_pause, 1'b1);
    press_pause();
    check_bit("game_pause", game_pause, 1'b0);
endtask

task automatic test_download();
    logic [21:0] addr;
    logic [7:0]  data;
    logic [1:0]  mask;
    downloading = 1'b1;
    repeat (4) @(negedge clk_sys);
    for (int i = 0; i < N_WR; i++) begin
        addr = WIN_BASE + 22'(take_bits(6));
        data = 8'(take_bits(8));
        mask = 2'(take_bits(2));
        prog_addr = addr;
        prog_data = data;
        prog_mask = mask;
        prog_we = 1'b1;
        if (mask[addr[0]] == 1'b0) begin
            shadow[int'(addr)] = data;        // Lane enabled by a 0 mask bit
        end
        @(negedge clk_sys);
        prog_we = 1'b0;
        repeat (WR_GAP - 1 + int'(take_bits(2))) @(negedge clk_sys);
    end
    downloading = 1'b0;
    @(negedge clk_sys);
    for (int i = 0; i < N_RD; i++) begin
        read_and_check(WIN_BASE + 22'(take_bits(6)));
    end
endtask

task automatic test_arbitration();
    time t_start;
    int  periods;
    if (refresh_seen != 0) stop_run("Refresh issued while refresh_en was low");
    downloading = 1'b1;
    sdram_req = 1'b1;
    sdram_addr = WIN_BASE + 22'(take_bits(6));
    for (int i = 0; i < HOLD_CYCLES; i++) begin
        @(negedge clk_sys);
        check_bit("sdram_ack", sdram_ack, 1'b0);   // Blocked by the loader
    end
    downloading = 1'b0;
    read_and_check(sdram_addr);
    refresh_en = 1'b1;
    t_start = $time;
    for (int i = 0; i < N_REF_RD; i++) begin
        repeat (int'(take_bits(5))) @(negedge clk_sys);
        read_and_check(WIN_BASE + 22'(take_bits(6)));
    end
    repeat (IDLE_TAIL) @(negedge clk_sys);
    refresh_en = 1'b0;
    periods = int'(($time - t_start) / CLK_PERIOD) / jtframe_pkg::REFRESH_PERIOD;
    if (refresh_seen < periods - 1) stop_run("Too few refresh commands with refresh_en high");
endtask

initial begin
    repeat (WATCHDOG) @(posedge clk_sys);
    stop_run("Watchdog expired before the tests finished");
end

initial begin
    arst_n = 1'b0;
    pll_locked = 1'b1;
    dip_flip = 1'b0;
    rst_req = 1'b0;
    downloading = 1'b0;
    refresh_en = 1'b0;
    sdram_req = 1'b0;
    sdram_addr = '0;
    prog_addr = '0;
    prog_data = '0;
    prog_mask = '0;
    prog_we = 1'b0;
    board_joystick1 = '0;
    board_joystick2 = '0;
    lfsr_state = LFSR_SEED;
    test_reset();
    test_game_reset();
    test_inputs();
    test_download();
    test_arbitration();
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
/* Memory model for the 16-bit request port
   Word store with an address-derived fill pattern and
   an LFSR-chosen response latency of 1 to 4 cycles */

`default_nettype none

module tb_mem_model(
    input  wire         clk_sys,
    input  wire         arst_n,
    input  wire  [20:0] mem_addr,
    input  wire  [15:0] mem_din,
    input  wire  [1:0]  mem_be,
    input  wire         mem_rd,
    input  wire         mem_we,
    input  wire         mem_refresh,
    output logic [15:0] mem_dout,
    output logic        mem_rdy
);

timeunit 1ns;
timeprecision 1ps;

logic [15:0] store [int];   // Only written words
logic [15:0] lat_lfsr;
logic [15:0] lfsr_one;
logic [15:0] lfsr_two;
logic        busy;
logic        op_rd;
logic        op_we;
logic [20:0] op_addr;
logic [15:0] op_din;
logic [1:0]  op_be;
logic [1:0]  wait_cnt;

// Unwritten words read back a pattern built from every address bit
function automatic logic [15:0] fill_word(input logic [20:0] a);
    return {a[7:0], a[15:8]} ^ {11'h000, a[20:16]} ^ 16'h5A3C;
endfunction

function automatic logic [15:0] read_word(input logic [20:0] a);
    if (store.exists(int'(a))) begin
        return store[int'(a)];
    end
    return fill_word(a);
endfunction

// Byte enables pick which lanes take the new data
function automatic logic [15:0] merge_word(input logic [15:0] old,
                                           input logic [15:0] din,
                                           input logic [1:0]  be);
    logic [15:0] w;
    w = old;
    if (be[1]) begin
        w[15:8] = din[15:8];
    end
    if (be[0]) begin
        w[7:0] = din[7:0];
    end
    return w;
endfunction

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

assign lfsr_one = lfsr_step(lat_lfsr);
assign lfsr_two = lfsr_step(lfsr_one);   // Two bits per latency

always @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
        lat_lfsr <= 16'd32541;
        busy     <= 1'b0;
        mem_rdy  <= 1'b0;
        mem_dout <= '0;
        wait_cnt <= '0;
        op_rd    <= 1'b0;
        op_we    <= 1'b0;
    end else begin
        mem_rdy <= 1'b0;
        if (mem_rd || mem_we || mem_refresh) begin
            op_rd    <= mem_rd;
            op_we    <= mem_we;
            op_addr  <= mem_addr;
            op_din   <= mem_din;
            op_be    <= mem_be;
            wait_cnt <= {lfsr_two[0], lfsr_one[0]};
            lat_lfsr <= lfsr_two;
            busy     <= 1'b1;
        end else if (busy) begin
            if (wait_cnt == 2'd0) begin
                mem_rdy <= 1'b1;
                busy    <= 1'b0;
                if (op_rd) begin
                    mem_dout <= read_word(op_addr);
                end
                if (op_we) begin
                    store[int'(op_addr)] = merge_word(read_word(op_addr), op_din, op_be);
                end
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end
end

endmodule

`default_nettype wire
